//--- common/surfacePkg.sv
package surfacePkg;

    // ----------------------------------------
    // Fixed point format
    // ----------------------------------------
    localparam int FixedWidth = 32;
    localparam int FracBits = 16;
    localparam logic signed [FixedWidth-1:0] FixedMax = {1'b0, {(FixedWidth - 1){1'b1}}};

    // Lanes per batch, and its log2
    localparam int TestUnitSize = 2;
    localparam int TestUnitSizeWidth = 1;

    localparam int PrimIndexWidth = 8;
    localparam int PrimCountWidth = 8;
    localparam int CheckerBit = 18;

    // Cycles from the last query to the last closest-hit update
    localparam int PipeDepth = 3;
    localparam int DrainWidth = 2;

    typedef logic [PrimIndexWidth-1:0] primIndexT;
    // One extra bit so an end index past the last entry does not wrap
    typedef logic [PrimIndexWidth:0] primSpanT;
    typedef logic [DrainWidth-1:0] drainCountT;

    localparam primIndexT GroundPrimIndex = '0;
    localparam primSpanT LaneStep = primSpanT'(TestUnitSize);
    localparam primSpanT LaneRound = primSpanT'(TestUnitSize - 1);
    localparam drainCountT DrainLast = drainCountT'(PipeDepth - 2);

    // ----------------------------------------
    // Shared records
    // ----------------------------------------
    typedef struct packed {
        logic signed [FixedWidth-1:0] x;
        logic signed [FixedWidth-1:0] y;
        logic signed [FixedWidth-1:0] z;
    } fixed3T;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    // invDir comes precomputed with the ray
    typedef struct packed {
        fixed3T origin;
        fixed3T dir;
        fixed3T invDir;
        primIndexT startPrim;
        logic [PrimCountWidth-1:0] numPrim;
        rgb8T clearColor;
    } rayT;

    typedef struct packed {
        fixed3T minCorner;
        fixed3T maxCorner;
        rgb8T color;
    } aabbT;

    // Asks for TestUnitSize boxes from baseIndex on
    typedef struct packed {
        logic queryValid;
        primIndexT baseIndex;
    } primQueryT;

    typedef struct packed {
        logic tagValid;
        primIndexT baseIndex;
        logic [TestUnitSize-1:0] laneMask;
    } batchTagT;

    typedef struct packed {
        logic hit;
        logic signed [FixedWidth-1:0] t;
        primIndexT primIndex;
    } laneHitT;

    typedef struct packed {
        logic hit;
        logic signed [FixedWidth-1:0] t;
        primIndexT primIndex;
        rgb8T color;
        logic isGround;
    } hitDataT;

    typedef struct packed {
        logic hit;
        primIndexT primIndex;
        logic signed [FixedWidth-1:0] t;
        fixed3T hitPos;
        rgb8T color;
        fixed3T viewDir;
    } surfaceOutT;

    // Q16.16 multiply with a full-width product
    function automatic logic signed [FixedWidth-1:0] fixedMul(
        input logic signed [FixedWidth-1:0] a,
        input logic signed [FixedWidth-1:0] b
    );
        logic signed [2*FixedWidth-1:0] prod;
        prod = a * b;
        return prod[FracBits +: FixedWidth];
    endfunction

endpackage

//--- intersect/aabbSlabTest.sv
`timescale 1ns/10ps

module aabbSlabTest (
    input  logic                  clk,
    input  logic                  resetn,
    input  surfacePkg::fixed3T    origin,
    input  surfacePkg::fixed3T    invDir,
    input  surfacePkg::aabbT      box,
    input  logic                  laneEnable,
    input  surfacePkg::primIndexT primIndex,
    output surfacePkg::laneHitT   laneHit
);

    logic [2:0][surfacePkg::FixedWidth-1:0] originAxes;
    logic [2:0][surfacePkg::FixedWidth-1:0] invAxes;
    logic [2:0][surfacePkg::FixedWidth-1:0] loAxes;
    logic [2:0][surfacePkg::FixedWidth-1:0] hiAxes;
    logic signed [surfacePkg::FixedWidth-1:0] tNear;
    logic signed [surfacePkg::FixedWidth-1:0] tFar;
    logic hitNow;

    // Axes as arrays so one loop covers x, y and z
    assign originAxes = origin;
    assign invAxes = invDir;
    assign loAxes = box.minCorner;
    assign hiAxes = box.maxCorner;

    // ----------------------------------------
    // Slab intervals
    // ----------------------------------------
    always_comb begin
        logic signed [surfacePkg::FixedWidth-1:0] t0;
        logic signed [surfacePkg::FixedWidth-1:0] t1;
        tNear = -surfacePkg::FixedMax;
        tFar = surfacePkg::FixedMax;
        for (int a = 0; a < 3; a++) begin
            t0 = surfacePkg::fixedMul(loAxes[a] - originAxes[a], invAxes[a]);
            t1 = surfacePkg::fixedMul(hiAxes[a] - originAxes[a], invAxes[a]);
            // Entry is the later of the near planes, exit the earlier far plane
            if (t0 < t1) begin
                tNear = (t0 > tNear) ? t0 : tNear;
                tFar = (t1 < tFar) ? t1 : tFar;
            end else begin
                tNear = (t1 > tNear) ? t1 : tNear;
                tFar = (t0 < tFar) ? t0 : tFar;
            end
        end
    end

    // Boxes behind the origin do not count
    assign hitNow = laneEnable && (tNear <= tFar) && (tNear >= 0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            laneHit <= '0;
        end else begin
            laneHit.hit <= hitNow;
            laneHit.t <= tNear;
            laneHit.primIndex <= primIndex;
        end
    end

endmodule

//--- intersect/closestHit.sv
`timescale 1ns/10ps

module closestHit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 startRay,
    input  surfacePkg::batchTagT batchTag,
    input  surfacePkg::aabbT     prims [surfacePkg::TestUnitSize],
    input  surfacePkg::rayT      curRay,
    output surfacePkg::hitDataT  hitData,
    output surfacePkg::fixed3T   hitPos
);

    surfacePkg::batchTagT tagD;
    surfacePkg::laneHitT laneHits [surfacePkg::TestUnitSize];
    surfacePkg::rgb8T laneColor [surfacePkg::TestUnitSize];
    surfacePkg::laneHitT best;
    surfacePkg::rgb8T bestColor;

    // Memory answers one cycle after the query
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tagD <= '0;
        end else begin
            tagD <= batchTag;
        end
    end

    for (genvar lane = 0; lane < surfacePkg::TestUnitSize; lane++) begin : gLane
        aabbSlabTest laneTest (
            .clk        (clk),
            .resetn     (resetn),
            .origin     (curRay.origin),
            .invDir     (curRay.invDir),
            .box        (prims[lane]),
            .laneEnable (tagD.tagValid & tagD.laneMask[lane]),
            .primIndex  (tagD.baseIndex + surfacePkg::primIndexT'(lane)),
            .laneHit    (laneHits[lane])
        );
    end

    // Colors follow the slab registers
    always_ff @(posedge clk) begin
        for (int i = 0; i < surfacePkg::TestUnitSize; i++) begin
            laneColor[i] <= prims[i].color;
        end
    end

    // Lower lane wins on equal t
    always_comb begin
        best = laneHits[0];
        bestColor = laneColor[0];
        for (int i = 1; i < surfacePkg::TestUnitSize; i++) begin
            if (laneHits[i].hit && (!best.hit || laneHits[i].t < best.t)) begin
                best = laneHits[i];
                bestColor = laneColor[i];
            end
        end
    end

    // ----------------------------------------
    // Running closest-hit record
    // ----------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            hitData <= '0;
            hitData.t <= surfacePkg::FixedMax;
        end else if (startRay) begin
            hitData.hit <= 1'b0;
            hitData.t <= surfacePkg::FixedMax;
            hitData.primIndex <= '0;
            hitData.color <= curRay.clearColor;
            hitData.isGround <= 1'b0;
        end else if (best.hit && best.t < hitData.t) begin
            hitData.hit <= 1'b1;
            hitData.t <= best.t;
            hitData.primIndex <= best.primIndex;
            hitData.color <= bestColor;
            hitData.isGround <= best.primIndex == surfacePkg::GroundPrimIndex;
        end
    end

    // origin + t * dir
    assign hitPos.x = curRay.origin.x + surfacePkg::fixedMul(hitData.t, curRay.dir.x);
    assign hitPos.y = curRay.origin.y + surfacePkg::fixedMul(hitData.t, curRay.dir.y);
    assign hitPos.z = curRay.origin.z + surfacePkg::fixedMul(hitData.t, curRay.dir.z);

endmodule

//--- design/primitiveSequencer.sv
`timescale 1ns/10ps

module primitiveSequencer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  addInput,
    input  surfacePkg::rayT       ray,
    output logic                  fifoFull,
    input  logic                  outputFull,
    output surfacePkg::primQueryT primQuery,
    output surfacePkg::batchTagT  batchTag,
    output surfacePkg::rayT       curRay,
    output logic                  startRay,
    output logic                  finish
);

    typedef enum logic [1:0] {Idle, Scan, Drain, Done} seqStateT;

    seqStateT state;
    surfacePkg::rayT rayBuf;
    surfacePkg::primSpanT batchIdx;
    surfacePkg::primSpanT alignedEnd;
    surfacePkg::primSpanT realEnd;
    surfacePkg::primSpanT startExt;
    surfacePkg::primSpanT numExt;
    surfacePkg::primSpanT alignedCount;
    surfacePkg::drainCountT drainCnt;
    logic [surfacePkg::TestUnitSize-1:0] laneMask;
    logic takeRay;
    logic moreBatches;

    assign takeRay = (state == Idle) && fifoFull;

    // Round the count up to whole batches
    assign startExt = surfacePkg::primSpanT'(rayBuf.startPrim);
    assign numExt = surfacePkg::primSpanT'(rayBuf.numPrim);
    assign alignedCount = ((numExt + surfacePkg::LaneRound) >> surfacePkg::TestUnitSizeWidth)
                          << surfacePkg::TestUnitSizeWidth;

    assign moreBatches = batchIdx < alignedEnd;

    // Padded lanes past the real end stay masked
    always_comb begin
        for (int i = 0; i < surfacePkg::TestUnitSize; i++) begin
            laneMask[i] = (batchIdx + surfacePkg::primSpanT'(i)) < realEnd;
        end
    end

    // Single-entry ray buffer
    always_ff @(posedge clk) begin
        if (addInput && !fifoFull) begin
            rayBuf <= ray;
        end
    end

    always_ff @(posedge clk) begin
        if (takeRay) begin
            curRay <= rayBuf;
        end
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= Idle;
            fifoFull <= 1'b0;
            startRay <= 1'b0;
            finish <= 1'b0;
            primQuery <= '0;
            batchTag <= '0;
            batchIdx <= '0;
            alignedEnd <= '0;
            realEnd <= '0;
            drainCnt <= '0;
        end else begin
            startRay <= 1'b0;
            finish <= 1'b0;
            primQuery.queryValid <= 1'b0;
            batchTag.tagValid <= 1'b0;

            if (takeRay) begin
                fifoFull <= 1'b0;
            end else if (addInput && !fifoFull) begin
                fifoFull <= 1'b1;
            end

            case (state)
                Idle: begin
                    if (fifoFull) begin
                        startRay <= 1'b1;
                        batchIdx <= startExt;
                        alignedEnd <= startExt + alignedCount;
                        realEnd <= startExt + numExt;
                        state <= Scan;
                    end
                end
                Scan: begin
                    // One batch per cycle
                    if (moreBatches) begin
                        primQuery.queryValid <= 1'b1;
                        primQuery.baseIndex <= surfacePkg::primIndexT'(batchIdx);
                        batchTag.tagValid <= 1'b1;
                        batchTag.baseIndex <= surfacePkg::primIndexT'(batchIdx);
                        batchTag.laneMask <= laneMask;
                        batchIdx <= batchIdx + surfacePkg::LaneStep;
                    end else begin
                        drainCnt <= '0;
                        state <= Drain;
                    end
                end
                Drain: begin
                    // Let the last batch reach the record
                    if (drainCnt == surfacePkg::DrainLast) begin
                        state <= Done;
                    end else begin
                        drainCnt <= drainCnt + 1'b1;
                    end
                end
                Done: begin
                    if (!outputFull) begin
                        finish <= 1'b1;
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

endmodule

//--- design/surfaceOutput.sv
`timescale 1ns/10ps

module surfaceOutput (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   finish,
    input  surfacePkg::hitDataT    hitData,
    input  surfacePkg::fixed3T     hitPos,
    input  surfacePkg::fixed3T     viewDir,
    output logic                   valid,
    output surfacePkg::surfaceOutT surfaceOut
);

    logic darken;
    surfacePkg::rgb8T shadedColor;

    // Ground checker from bit 18 of x ^ z
    assign darken = hitData.hit && hitData.isGround
                    && (hitPos.x[surfacePkg::CheckerBit] ^ hitPos.z[surfacePkg::CheckerBit]);

    always_comb begin
        shadedColor = hitData.color;
        if (darken) begin
            shadedColor.r = hitData.color.r >> 1;
            shadedColor.g = hitData.color.g >> 1;
            shadedColor.b = hitData.color.b >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            surfaceOut.hit <= hitData.hit;
            surfaceOut.primIndex <= hitData.primIndex;
            surfaceOut.t <= hitData.t;
            surfaceOut.hitPos <= hitPos;
            surfaceOut.color <= shadedColor;
            surfaceOut.viewDir <= viewDir;
        end
    end

    // One pulse per ray
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= finish;
        end
    end

endmodule

//--- design/surfaceUnit.sv
`timescale 1ns/10ps

module surfaceUnit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   addInput,
    input  surfacePkg::rayT        ray,
    output logic                   fifoFull,
    output surfacePkg::primQueryT  primQuery,
    input  surfacePkg::aabbT       prims [surfacePkg::TestUnitSize],
    input  logic                   outputFull,
    output logic                   valid,
    output surfacePkg::surfaceOutT surfaceOut
);

    surfacePkg::batchTagT batchTag;
    surfacePkg::rayT curRay;
    surfacePkg::hitDataT hitData;
    surfacePkg::fixed3T hitPos;
    logic startRay;
    logic finish;

    // Decode
    primitiveSequencer sequencer_i (
        .clk        (clk),
        .resetn     (resetn),
        .addInput   (addInput),
        .ray        (ray),
        .fifoFull   (fifoFull),
        .outputFull (outputFull),
        .primQuery  (primQuery),
        .batchTag   (batchTag),
        .curRay     (curRay),
        .startRay   (startRay),
        .finish     (finish)
    );

    // Execute
    closestHit closestHit_i (
        .clk      (clk),
        .resetn   (resetn),
        .startRay (startRay),
        .batchTag (batchTag),
        .prims    (prims),
        .curRay   (curRay),
        .hitData  (hitData),
        .hitPos   (hitPos)
    );

    // Result
    surfaceOutput surfaceOutput_i (
        .clk        (clk),
        .resetn     (resetn),
        .finish     (finish),
        .hitData    (hitData),
        .hitPos     (hitPos),
        .viewDir    (curRay.dir),
        .valid      (valid),
        .surfaceOut (surfaceOut)
    );

endmodule

//--- testbench/surfaceChecker.sv
`timescale 1ns/10ps

module surfaceChecker #(
    parameter int NumRays = 60,
    parameter int MaxPrim = 16
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   addInput,
    input  surfacePkg::rayT        ray,
    input  logic                   fifoFull,
    input  logic                   outputFull,
    input  logic                   valid,
    input  surfacePkg::surfaceOutT surfaceOut,
    input  surfacePkg::aabbT       primMem [256],
    output int                     errorCount,
    output int                     resultCount,
    output int                     pendingCount,
    output logic                   timedOut
);

    localparam int CycleLimit = NumRays * (MaxPrim / 2 + 12) + 100;

    surfacePkg::surfaceOutT expected [$];
    int pushCount = 0;
    int mismatchCount = 0;
    int cycleCount = 0;
    logic fullAtEdge1 = 1'b0;
    logic fullAtEdge2 = 1'b0;
    logic acceptedLast = 1'b0;

    assign pendingCount = pushCount - resultCount;
    assign errorCount = mismatchCount + (timedOut ? 1 : 0);

    // Q16.16 product from bits 47:16 of the wide result
    function automatic logic signed [31:0] mulQ(input logic signed [31:0] a,
                                                input logic signed [31:0] b);
        logic signed [63:0] wide;
        wide = a;
        wide = wide * b;
        return wide[47:16];
    endfunction

    function automatic logic slabHit(input surfacePkg::rayT r, input surfacePkg::aabbT b,
                                     output logic signed [31:0] tEnter);
        logic signed [31:0] o [3];
        logic signed [31:0] inv [3];
        logic signed [31:0] lo [3];
        logic signed [31:0] hi [3];
        logic signed [31:0] ta;
        logic signed [31:0] tb;
        logic signed [31:0] tExit;
        o = '{r.origin.x, r.origin.y, r.origin.z};
        inv = '{r.invDir.x, r.invDir.y, r.invDir.z};
        lo = '{b.minCorner.x, b.minCorner.y, b.minCorner.z};
        hi = '{b.maxCorner.x, b.maxCorner.y, b.maxCorner.z};
        tEnter = -surfacePkg::FixedMax;
        tExit = surfacePkg::FixedMax;
        for (int a = 0; a < 3; a++) begin
            ta = mulQ(lo[a] - o[a], inv[a]);
            tb = mulQ(hi[a] - o[a], inv[a]);
            if (ta > tb) begin
                {ta, tb} = {tb, ta};
            end
            tEnter = (ta > tEnter) ? ta : tEnter;
            tExit = (tb < tExit) ? tb : tExit;
        end
        return (tEnter <= tExit) && (tEnter >= 0);
    endfunction

    function automatic surfacePkg::surfaceOutT expectSurface(input surfacePkg::rayT r);
        surfacePkg::surfaceOutT e;
        logic signed [31:0] tCand;
        logic [7:0] idx;
        e = '0;
        e.t = surfacePkg::FixedMax;
        e.color = r.clearColor;
        e.viewDir = r.dir;
        // Index order with strict compare keeps the lower index on ties
        for (int i = 0; i < int'(r.numPrim); i++) begin
            idx = r.startPrim + 8'(i);
            if (slabHit(r, primMem[idx], tCand) && tCand < e.t) begin
                e.hit = 1'b1;
                e.t = tCand;
                e.primIndex = idx;
                e.color = primMem[idx].color;
            end
        end
        e.hitPos.x = r.origin.x + mulQ(e.t, r.dir.x);
        e.hitPos.y = r.origin.y + mulQ(e.t, r.dir.y);
        e.hitPos.z = r.origin.z + mulQ(e.t, r.dir.z);
        if (e.hit && e.primIndex == 8'd0 && (e.hitPos.x[18] ^ e.hitPos.z[18])) begin
            e.color.r = e.color.r >> 1;
            e.color.g = e.color.g >> 1;
            e.color.b = e.color.b >> 1;
        end
        return e;
    endfunction

    task automatic checkField(input string name, input logic [95:0] expV,
                              input logic [95:0] actV);
        if (expV !== actV) begin
            mismatchCount++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expV, actV);
        end
    endtask

    // Acceptance, back-pressure history and cycle limit
    always @(posedge clk) begin
        // The buffer shows full on the edge after it takes a ray
        if (acceptedLast) begin
            checkField("fifoFull", 96'(1'b1), 96'(fifoFull));
        end
        acceptedLast = resetn && addInput && !fifoFull;
        if (acceptedLast) begin
            expected.push_back(expectSurface(ray));
            pushCount++;
        end
        fullAtEdge2 = fullAtEdge1;
        fullAtEdge1 = outputFull;
        cycleCount++;
        if (cycleCount == CycleLimit) begin
            $display("Timeout: run passed the limit of %0d cycles", CycleLimit);
        end
    end

    assign timedOut = cycleCount >= CycleLimit;

    always @(negedge clk) begin
        surfacePkg::surfaceOutT e;
        if (resetn && valid) begin
            if (fullAtEdge2) begin
                mismatchCount++;
                $display("Result at %0t ns was released while outputFull was high", $time);
            end
            if (expected.size() == 0) begin
                mismatchCount++;
                $display("Result at %0t ns arrived with no ray pending", $time);
            end else begin
                e = expected.pop_front();
                resultCount++;
                checkField("hit", 96'(e.hit), 96'(surfaceOut.hit));
                checkField("primIndex", 96'(e.primIndex), 96'(surfaceOut.primIndex));
                checkField("t", 96'(e.t), 96'(surfaceOut.t));
                checkField("hitPos", e.hitPos, surfaceOut.hitPos);
                checkField("color", 96'(e.color), 96'(surfaceOut.color));
                checkField("viewDir", e.viewDir, surfaceOut.viewDir);
            end
        end
    end

endmodule

//--- testbench/surfaceUnitTb.sv
`timescale 1ns/10ps

module surfaceUnitTb;

    localparam int NumRays = 60;
    localparam int MaxPrim = 16;

    logic clk = 1'b0;
    logic resetn;
    logic addInput;
    surfacePkg::rayT ray;
    logic fifoFull;
    surfacePkg::primQueryT primQuery;
    surfacePkg::aabbT prims [surfacePkg::TestUnitSize];
    logic outputFull;
    logic valid;
    surfacePkg::surfaceOutT surfaceOut;
    surfacePkg::aabbT primMem [256];
    logic [31:0] lcgState = 32'h3796_2107;
    int errorCount;
    int resultCount;
    int pendingCount;
    logic timedOut;

    always #2 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randRange(input int lo, input int hi);
        return lo + int'((lcgNext() >> 8) % (hi - lo + 1));
    endfunction

    // Coordinates are kept in quarter units
    function automatic logic signed [31:0] quarters(input int q);
        return 32'(q * 16384);
    endfunction

    // ----------------------------------------
    // Primitive memory
    // ----------------------------------------
    always @(posedge clk) begin
        if (primQuery.queryValid) begin
            for (int k = 0; k < surfacePkg::TestUnitSize; k++) begin
                prims[k] <= primMem[primQuery.baseIndex + 8'(k)];
            end
        end
    end

    task automatic fillMemory();
        int cx;
        int cy;
        int cz;
        int hs;
        for (int a = 0; a < 256; a++) begin
            if (a == 0) begin
                // Wide flat ground slab under everything
                primMem[a].minCorner = '{quarters(-256), quarters(-8), quarters(-256)};
                primMem[a].maxCorner = '{quarters(256), quarters(0), quarters(256)};
            end else if (a % 4 == 1) begin
                // Same geometry as the box before it so hits can tie
                primMem[a] = primMem[a - 1];
            end else begin
                cx = randRange(-48, 48);
                cy = randRange(-16, 48);
                cz = randRange(-48, 48);
                hs = randRange(2, 16);
                primMem[a].minCorner = '{quarters(cx - hs), quarters(cy - hs), quarters(cz - hs)};
                primMem[a].maxCorner = '{quarters(cx + hs), quarters(cy + hs), quarters(cz + hs)};
            end
            primMem[a].color = surfacePkg::rgb8T'(lcgNext() ^ 32'(a));
        end
    endtask

    // Direction steps of 0.25 to 2.0 so invDir is exact
    function automatic void pickAxis(input int downBias, output logic signed [31:0] d,
                                     output logic signed [31:0] inv);
        int k;
        k = randRange(0, 3);
        d = 32'sd1 <<< (14 + k);
        inv = 32'sd1 <<< (18 - k);
        if (randRange(0, 3) < downBias) begin
            d = -d;
            inv = -inv;
        end
    endfunction

    function automatic surfacePkg::rayT makeRay(input int n);
        surfacePkg::rayT r;
        r.origin = '{quarters(randRange(-80, 80)), quarters(randRange(4, 80)),
                     quarters(randRange(-80, 80))};
        pickAxis(2, r.dir.x, r.invDir.x);
        pickAxis(3, r.dir.y, r.invDir.y);
        pickAxis(2, r.dir.z, r.invDir.z);
        r.startPrim = (randRange(0, 1) == 0) ? 8'd0 : 8'(randRange(0, 200));
        r.numPrim = (n == 0) ? 8'd0 : 8'(randRange(0, MaxPrim - 1));
        r.clearColor = surfacePkg::rgb8T'(lcgNext());
        return r;
    endfunction

    task automatic sendRay(input surfacePkg::rayT r);
        ray = r;
        addInput = 1'b1;
        while (fifoFull && !timedOut) begin
            @(negedge clk);
        end
        @(negedge clk);
        addInput = 1'b0;
        repeat (randRange(0, 2)) @(negedge clk);
    endtask

    surfaceUnit dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .addInput   (addInput),
        .ray        (ray),
        .fifoFull   (fifoFull),
        .primQuery  (primQuery),
        .prims      (prims),
        .outputFull (outputFull),
        .valid      (valid),
        .surfaceOut (surfaceOut)
    );

    surfaceChecker #(.NumRays(NumRays), .MaxPrim(MaxPrim)) checker_i (
        .clk          (clk),
        .resetn       (resetn),
        .addInput     (addInput),
        .ray          (ray),
        .fifoFull     (fifoFull),
        .outputFull   (outputFull),
        .valid        (valid),
        .surfaceOut   (surfaceOut),
        .primMem      (primMem),
        .errorCount   (errorCount),
        .resultCount  (resultCount),
        .pendingCount (pendingCount),
        .timedOut     (timedOut)
    );

    // Random stretches of back-pressure
    initial begin
        outputFull = 1'b0;
        @(posedge resetn);
        forever begin
            repeat (randRange(2, 9)) @(negedge clk);
            outputFull = 1'b1;
            repeat (randRange(0, 3)) @(negedge clk);
            outputFull = 1'b0;
        end
    end

    initial begin
        resetn = 1'b0;
        addInput = 1'b0;
        ray = '0;
        prims = '{default: '0};
        fillMemory();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int n = 0; n < NumRays; n++) begin
            if (!timedOut) begin
                sendRay(makeRay(n));
            end
        end
        while (pendingCount != 0 && !timedOut) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("Results checked %0d, errors %0d, pending %0d",
                 resultCount, errorCount, pendingCount);
        if (pendingCount != 0) begin
            $display("Run ended with %0d rays still waiting for a result", pendingCount);
        end
        if (errorCount == 0 && pendingCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- surfaceUnit.f
common/surfacePkg.sv
intersect/aabbSlabTest.sv
intersect/closestHit.sv
design/primitiveSequencer.sv
design/surfaceOutput.sv
design/surfaceUnit.sv
testbench/surfaceChecker.sv
testbench/surfaceUnitTb.sv

//--- run.sh
#!/bin/sh
verilator --binary -Wno-fatal --top-module surfaceUnitTb -f surfaceUnit.f -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    && ! grep -q "Errors found" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
